// File: Makefile
TOP = tb_mmu

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only --top-module mmu_top \
		rtl/mmu_pkg.sv rtl/pte_perm_check.sv rtl/tlb.sv \
		rtl/page_walker.sv rtl/mmu_top.sv
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: rtl/mmu_pkg.sv
package mmu_pkg;

    localparam int va_w          = 32;
    localparam int pa_w          = 34;
    localparam int ppn_w         = 22;
    localparam int vpn_w         = 20;
    localparam int page_off_w    = 12;
    localparam int tlb_entries   = 4;
    localparam int pte_size_log2 = 2;

    // one sv32 level indexes 10 vpn bits
    localparam int vpn_lvl_w     = vpn_w / 2;
    localparam int tlb_idx_w     = $clog2(tlb_entries);

    typedef logic [va_w-1:0]  vaddr_t;
    typedef logic [pa_w-1:0]  paddr_t;
    typedef logic [ppn_w-1:0] ppn_t;
    typedef logic [vpn_w-1:0] vpn_t;
    typedef logic [31:0]      wb_data_t;

    typedef enum logic [1:0] {
        acc_read,
        acc_write,
        acc_exec
    } access_t;

    typedef enum logic [1:0] {
        prv_u = 2'd0,
        prv_s = 2'd1,
        prv_m = 2'd3
    } prv_t;

    typedef enum logic [1:0] {
        flt_none,
        flt_page,
        flt_bus
    } fault_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_fetch,
        st_eval,
        st_done
    } walk_state_t;

    // sv32 pte, msb first
    typedef struct packed {
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    typedef struct packed {
        vaddr_t  va;
        access_t acc;
        prv_t    prv;
        logic    sum;
    } mmu_req_t;

    typedef struct packed {
        logic mode;
        ppn_t ppn;
    } satp_t;

    typedef struct packed {
        vpn_t vpn;
        logic mega;
        pte_t pte;
        logic valid;
    } tlb_entry_t;

    typedef struct packed {
        logic   cyc;
        logic   stb;
        logic   we;
        paddr_t adr;
    } wb_req_t;

endpackage

// File: rtl/mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
    input  logic              clk,
    input  logic              rstn,
    input  logic              req_valid,
    input  mmu_pkg::mmu_req_t req,
    input  mmu_pkg::satp_t    satp,
    input  logic              flush,
    input  mmu_pkg::wb_data_t wb_dat_i,
    input  logic              wb_ack,
    input  logic              wb_err,
    output logic              busy,
    output logic              pa_valid,
    output mmu_pkg::paddr_t   pa,
    output mmu_pkg::fault_t   fault,
    output mmu_pkg::wb_req_t  wb
);
    import mmu_pkg::*;

    vpn_t       lookup_vpn;
    logic       tlb_hit;
    tlb_entry_t tlb_hit_entry;
    logic       fill;
    tlb_entry_t fill_entry;
    pte_t       chk_pte;
    logic       chk_mega;
    mmu_req_t   chk_req;
    logic       page_fault;

    page_walker i_page_walker (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req           (req),
        .satp          (satp),
        .wb_dat_i      (wb_dat_i),
        .wb_ack        (wb_ack),
        .wb_err        (wb_err),
        .tlb_hit       (tlb_hit),
        .tlb_hit_entry (tlb_hit_entry),
        .page_fault    (page_fault),
        .busy          (busy),
        .pa_valid      (pa_valid),
        .pa            (pa),
        .fault         (fault),
        .wb            (wb),
        .lookup_vpn    (lookup_vpn),
        .fill          (fill),
        .fill_entry    (fill_entry),
        .chk_pte       (chk_pte),
        .chk_mega      (chk_mega),
        .chk_req       (chk_req)
    );

    tlb i_tlb (
        .clk        (clk),
        .rstn       (rstn),
        .lookup_vpn (lookup_vpn),
        .fill       (fill),
        .fill_entry (fill_entry),
        .flush      (flush),
        .hit        (tlb_hit),
        .hit_entry  (tlb_hit_entry)
    );

    pte_perm_check i_pte_perm_check (
        .pte        (chk_pte),
        .mega       (chk_mega),
        .req        (chk_req),
        .page_fault (page_fault)
    );

endmodule

// File: rtl/page_walker.sv
`timescale 1ns/1ps

module page_walker (
    input  logic                clk,
    input  logic                rstn,
    input  logic                req_valid,
    input  mmu_pkg::mmu_req_t   req,
    input  mmu_pkg::satp_t      satp,
    input  mmu_pkg::wb_data_t   wb_dat_i,
    input  logic                wb_ack,
    input  logic                wb_err,
    input  logic                tlb_hit,
    input  mmu_pkg::tlb_entry_t tlb_hit_entry,
    input  logic                page_fault,
    output logic                busy,
    output logic                pa_valid,
    output mmu_pkg::paddr_t     pa,
    output mmu_pkg::fault_t     fault,
    output mmu_pkg::wb_req_t    wb,
    output mmu_pkg::vpn_t       lookup_vpn,
    output logic                fill,
    output mmu_pkg::tlb_entry_t fill_entry,
    output mmu_pkg::pte_t       chk_pte,
    output logic                chk_mega,
    output mmu_pkg::mmu_req_t   chk_req
);
    import mmu_pkg::*;

    walk_state_t          state_q;
    mmu_req_t             req_q;
    logic                 bypass_q;
    ppn_t                 root_ppn_q;
    ppn_t                 tbl_ppn_q;
    // 1 while on the root table, doubles as the megapage flag at a leaf
    logic                 level_q;
    logic                 from_tlb_q;
    pte_t                 pte_q;
    paddr_t               pa_q;
    fault_t               fault_q;
    logic [vpn_lvl_w-1:0] vpn_slice;
    logic                 is_ptr;
    paddr_t               leaf_pa;

    assign vpn_slice = level_q ? req_q.va[va_w-1 -: vpn_lvl_w]
                               : req_q.va[page_off_w +: vpn_lvl_w];

    // valid pointer to the next level
    assign is_ptr = pte_q.v & ~pte_q.r & ~pte_q.w & ~pte_q.x;

    // megapage keeps va bits 21:12
    assign leaf_pa = {pte_q.ppn[ppn_w-1:vpn_lvl_w],
                      level_q ? req_q.va[page_off_w +: vpn_lvl_w]
                              : pte_q.ppn[vpn_lvl_w-1:0],
                      req_q.va[page_off_w-1:0]};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (req_valid) begin
                        state_q <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (bypass_q) begin
                        state_q <= st_done;
                    end else if (tlb_hit) begin
                        state_q <= st_eval;
                    end else begin
                        state_q <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (wb_err) begin
                        state_q <= st_done;
                    end else if (wb_ack) begin
                        state_q <= st_eval;
                    end
                end
                st_eval: begin
                    if (is_ptr && level_q) begin
                        state_q <= st_fetch;
                    end else begin
                        state_q <= st_done;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            st_idle: begin
                if (req_valid) begin
                    req_q      <= req;
                    bypass_q   <= (satp.mode == 1'b0) || (req.prv == prv_m);
                    root_ppn_q <= satp.ppn;
                end
            end
            st_lookup: begin
                if (bypass_q) begin
                    pa_q    <= {{(pa_w - va_w){1'b0}}, req_q.va};
                    fault_q <= flt_none;
                end else if (tlb_hit) begin
                    pte_q      <= tlb_hit_entry.pte;
                    level_q    <= tlb_hit_entry.mega;
                    from_tlb_q <= 1'b1;
                end else begin
                    tbl_ppn_q  <= root_ppn_q;
                    level_q    <= 1'b1;
                    from_tlb_q <= 1'b0;
                end
            end
            st_fetch: begin
                if (wb_err) begin
                    fault_q <= flt_bus;
                end else if (wb_ack) begin
                    pte_q <= pte_t'(wb_dat_i);
                end
            end
            st_eval: begin
                if (is_ptr) begin
                    if (level_q) begin
                        tbl_ppn_q <= pte_q.ppn;
                        level_q   <= 1'b0;
                    end else begin
                        fault_q <= flt_page;
                    end
                end else if (page_fault) begin
                    fault_q <= flt_page;
                end else begin
                    fault_q <= flt_none;
                    pa_q    <= leaf_pa;
                end
            end
            default: begin
            end
        endcase
    end

    // wishbone classic read, one transfer at a time
    always_comb begin
        wb.cyc = (state_q == st_fetch);
        wb.stb = (state_q == st_fetch);
        wb.we  = 1'b0;
        wb.adr = {tbl_ppn_q, vpn_slice, {pte_size_log2{1'b0}}};
    end

    // clean leaf from a walk goes into the tlb
    assign fill = (state_q == st_eval) && !is_ptr && !page_fault && !from_tlb_q;

    always_comb begin
        fill_entry.vpn   = req_q.va[va_w-1:page_off_w];
        fill_entry.mega  = level_q;
        fill_entry.pte   = pte_q;
        fill_entry.valid = 1'b1;
    end

    assign lookup_vpn = req_q.va[va_w-1:page_off_w];
    assign chk_pte    = pte_q;
    assign chk_mega   = level_q;
    assign chk_req    = req_q;

    assign busy     = (state_q != st_idle);
    assign pa_valid = (state_q == st_done);
    assign pa       = pa_q;
    assign fault    = fault_q;

endmodule

// File: rtl/pte_perm_check.sv
`timescale 1ns/1ps

module pte_perm_check (
    input  mmu_pkg::pte_t     pte,
    input  logic              mega,
    input  mmu_pkg::mmu_req_t req,
    output logic              page_fault
);
    import mmu_pkg::*;

    logic is_rd;
    logic is_wr;
    logic is_ex;
    logic bad_fmt;
    logic bad_align;
    logic bad_acc;
    logic bad_priv;
    logic bad_ad;

    assign is_rd = (req.acc == acc_read);
    assign is_wr = (req.acc == acc_write);
    assign is_ex = (req.acc == acc_exec);

    // invalid, or the reserved w-without-r encoding
    assign bad_fmt = !pte.v || (pte.w && !pte.r);

    // megapage must be 4 MiB aligned
    assign bad_align = mega && (|pte.ppn[vpn_lvl_w-1:0]);

    assign bad_acc = (is_rd && !pte.r)
                  || (is_wr && !pte.w)
                  || (is_ex && !pte.x);

    // supervisor never executes user pages, even with sum
    assign bad_priv = ((req.prv == prv_u) && !pte.u)
                   || ((req.prv == prv_s) && pte.u && (!req.sum || is_ex));

    // no hardware a/d update, so both must already be set
    assign bad_ad = !pte.a || (is_wr && !pte.d);

    assign page_fault = bad_fmt || bad_align || bad_acc || bad_priv || bad_ad;

endmodule

// File: rtl/tlb.sv
`timescale 1ns/1ps

module tlb (
    input  logic                clk,
    input  logic                rstn,
    input  mmu_pkg::vpn_t       lookup_vpn,
    input  logic                fill,
    input  mmu_pkg::tlb_entry_t fill_entry,
    input  logic                flush,
    output logic                hit,
    output mmu_pkg::tlb_entry_t hit_entry
);
    import mmu_pkg::*;

    tlb_entry_t             ent_q [tlb_entries];
    logic [tlb_entries-1:0] valid_q;
    logic [tlb_entries-1:0] match;
    logic [tlb_idx_w-1:0]   rr_q;
    logic [tlb_idx_w-1:0]   hit_idx;

    // megapage entries ignore the low vpn level
    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            match[i] = valid_q[i]
                && (ent_q[i].vpn[vpn_w-1:vpn_lvl_w] == lookup_vpn[vpn_w-1:vpn_lvl_w])
                && (ent_q[i].mega
                    || (ent_q[i].vpn[vpn_lvl_w-1:0] == lookup_vpn[vpn_lvl_w-1:0]));
        end
    end

    // lowest index wins
    always_comb begin
        hit_idx = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = tlb_idx_w'(i);
            end
        end
    end

    assign hit       = |match;
    assign hit_entry = ent_q[hit_idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[rr_q] <= fill_entry.valid;
            rr_q          <= rr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill && !flush) begin
            ent_q[rr_q] <= fill_entry;
        end
    end

endmodule

// File: testbench/tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu;
    import mmu_pkg::*;

    localparam int   req_timeout  = 64;
    localparam int   idle_timeout = 64;
    localparam ppn_t root_ppn     = 22'h00010;
    localparam ppn_t perm_tbl     = 22'h00012;
    localparam vpn_t page_vpn     = 20'h00402;
    localparam ppn_t page_ppn     = 22'h23456;

    // pte flag bits
    localparam logic [7:0] f_v = 8'h01;
    localparam logic [7:0] f_r = 8'h02;
    localparam logic [7:0] f_w = 8'h04;
    localparam logic [7:0] f_x = 8'h08;
    localparam logic [7:0] f_u = 8'h10;
    localparam logic [7:0] f_a = 8'h40;
    localparam logic [7:0] f_d = 8'h80;

    localparam satp_t sv32 = {1'b1, root_ppn};
    localparam satp_t bare = {1'b0, root_ppn};

    logic        clk;
    logic        rstn;
    logic        req_valid;
    mmu_req_t    req;
    satp_t       satp;
    logic        flush;
    wb_data_t    wb_dat;
    logic        wb_ack;
    logic        wb_err;
    logic        busy;
    logic        pa_valid;
    paddr_t      pa;
    fault_t      fault;
    wb_req_t     wb;
    paddr_t      err_lo;
    paddr_t      err_hi;
    logic [31:0] xfer_count;
    logic [31:0] lfsr_q;
    int          checks;
    int          errors;

    mmu_top i_mmu_top (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req       (req),
        .satp      (satp),
        .flush     (flush),
        .wb_dat_i  (wb_dat),
        .wb_ack    (wb_ack),
        .wb_err    (wb_err),
        .busy      (busy),
        .pa_valid  (pa_valid),
        .pa        (pa),
        .fault     (fault),
        .wb        (wb)
    );

    tb_pt_mem i_pt_mem (
        .clk    (clk),
        .rstn   (rstn),
        .wb     (wb),
        .err_lo (err_lo),
        .err_hi (err_hi),
        .dat    (wb_dat),
        .ack    (wb_ack),
        .err    (wb_err),
        .xfers  (xfer_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic wb_data_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    // byte address of entry idx in the table at ppn
    function automatic paddr_t pte_addr(input ppn_t ppn, input logic [9:0] idx);
        return {ppn, idx, 2'b00};
    endfunction

    function automatic mmu_req_t make_req(input vaddr_t va, input access_t acc,
                                          input prv_t prv, input logic sum);
        mmu_req_t r;
        r.va  = va;
        r.acc = acc;
        r.prv = prv;
        r.sum = sum;
        return r;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [11:0] random_offset();
        logic [11:0] v = '0;
        for (int i = 0; i < 12; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[10:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s = %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic wait_idle();
        int n = 0;
        @(negedge clk);
        while (busy && n < idle_timeout) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            errors++;
            $display("timeout: DUT still busy after %0d cycles", idle_timeout);
        end
    endtask

    task automatic translate(input mmu_req_t r, input satp_t s, output paddr_t got_pa,
                             output fault_t got_fault, output int lat, output int xfers);
        logic [31:0] start;
        logic        done;
        wait_idle();
        start     = xfer_count;
        got_pa    = '0;
        got_fault = flt_none;
        done      = 1'b0;
        lat       = 0;
        @(posedge clk);
        req       <= r;
        satp      <= s;
        req_valid <= 1'b1;
        // idle DUT takes it on this edge
        @(posedge clk);
        req_valid <= 1'b0;
        while (!done && lat < req_timeout) begin
            @(negedge clk);
            lat++;
            if (pa_valid) begin
                done      = 1'b1;
                got_pa    = pa;
                got_fault = fault;
            end
        end
        if (!done) begin
            errors++;
            $display("timeout: no pa_valid within %0d cycles of the request", req_timeout);
        end else begin
            @(negedge clk);
            compare("busy", 64'(busy), 64'd0);
        end
        xfers = int'(xfer_count - start);
    endtask

    // exp_lat of 0 leaves the latency unchecked
    task automatic expect_result(input mmu_req_t r, input satp_t s, input fault_t exp_fault,
                                 input paddr_t exp_pa, input int exp_xfers, input int exp_lat);
        paddr_t got_pa;
        fault_t got_fault;
        int     lat;
        int     xfers;
        translate(r, s, got_pa, got_fault, lat, xfers);
        compare("fault", 64'(got_fault), 64'(exp_fault));
        if (exp_fault == flt_none) begin
            compare("pa", 64'(got_pa), 64'(exp_pa));
        end
        compare("wb transfers", 64'(xfers), 64'(exp_xfers));
        if (exp_lat > 0) begin
            compare("latency", 64'(lat), 64'(exp_lat));
        end
    endtask

    task automatic run_bypass();
        vaddr_t va;
        va = {20'hdead5, random_offset()};
        expect_result(make_req(va, acc_read, prv_s, 1'b0), bare, flt_none, {2'b00, va}, 0, 2);
        va = {20'h80001, random_offset()};
        expect_result(make_req(va, acc_write, prv_m, 1'b0), sv32, flt_none, {2'b00, va}, 0, 2);
    endtask

    task automatic walk_then_hit();
        vaddr_t va;
        i_pt_mem.store(pte_addr(root_ppn, page_vpn[19:10]), make_pte(22'h00011, f_v));
        i_pt_mem.store(pte_addr(22'h00011, page_vpn[9:0]),
                       make_pte(page_ppn, f_v | f_r | f_w | f_a | f_d));
        va = {page_vpn, random_offset()};
        expect_result(make_req(va, acc_read, prv_s, 1'b0), sv32, flt_none,
                      {page_ppn, va[11:0]}, 2, 0);
        va = {page_vpn, random_offset()};
        expect_result(make_req(va, acc_write, prv_s, 1'b0), sv32, flt_none,
                      {page_ppn, va[11:0]}, 0, 3);
    endtask

    task automatic megapage_cases();
        ppn_t   mega_ppn;
        vaddr_t va;
        mega_ppn = 22'h05400;
        i_pt_mem.store(pte_addr(root_ppn, 10'h003), make_pte(mega_ppn, f_v | f_r | f_x | f_a));
        va = {10'h003, 10'h155, random_offset()};
        expect_result(make_req(va, acc_exec, prv_s, 1'b0), sv32, flt_none,
                      {mega_ppn[21:10], va[21:0]}, 1, 0);
        // another 4 KiB slice of the same megapage hits
        va = {10'h003, 10'h2aa, random_offset()};
        expect_result(make_req(va, acc_read, prv_s, 1'b0), sv32, flt_none,
                      {mega_ppn[21:10], va[21:0]}, 0, 3);
        // misaligned megapage faults and never reaches the tlb
        i_pt_mem.store(pte_addr(root_ppn, 10'h004), make_pte(22'h05401, f_v | f_r | f_x | f_a));
        va = {10'h004, 10'h000, random_offset()};
        expect_result(make_req(va, acc_read, prv_s, 1'b0), sv32, flt_page, '0, 1, 0);
        expect_result(make_req(va, acc_read, prv_s, 1'b0), sv32, flt_page, '0, 1, 0);
    endtask

    task automatic perm_case(input logic [9:0] idx, input logic [7:0] flags, input access_t acc,
                             input prv_t prv, input logic sum, input fault_t exp_fault);
        vaddr_t va;
        va = {10'h005, idx, random_offset()};
        i_pt_mem.store(pte_addr(perm_tbl, idx), make_pte({12'h001, idx}, flags));
        expect_result(make_req(va, acc, prv, sum), sv32, exp_fault,
                      {12'h001, idx, va[11:0]}, 2, 0);
    endtask

    task automatic permission_cases();
        i_pt_mem.store(pte_addr(root_ppn, 10'h005), make_pte(perm_tbl, f_v));
        perm_case(10'd0, f_v | f_r | f_w | f_a | f_d, acc_exec, prv_s, 1'b0, flt_page);
        perm_case(10'd1, f_v | f_r | f_w | f_u | f_a | f_d, acc_read, prv_s, 1'b0, flt_page);
        perm_case(10'd2, f_v | f_r | f_w | f_a, acc_write, prv_s, 1'b0, flt_page);
        perm_case(10'd3, f_v | f_r | f_w | f_d, acc_read, prv_s, 1'b0, flt_page);
        // w without r, exec with x set so only the encoding rule applies
        perm_case(10'd4, f_v | f_w | f_x | f_a | f_d, acc_exec, prv_s, 1'b0, flt_page);
        // pointer found at level 0
        perm_case(10'd5, f_v, acc_read, prv_s, 1'b0, flt_page);
        perm_case(10'd6, f_v | f_r | f_w | f_u | f_a | f_d, acc_read, prv_s, 1'b1, flt_none);
    endtask

    task automatic bus_error_case();
        @(posedge clk);
        err_lo <= pte_addr(root_ppn, 10'h006);
        err_hi <= pte_addr(root_ppn, 10'h006);
        expect_result(make_req({10'h006, 10'h001, 12'h123}, acc_read, prv_s, 1'b0), sv32,
                      flt_bus, '0, 1, 0);
        // error on the second level fetch
        i_pt_mem.store(pte_addr(root_ppn, 10'h007), make_pte(22'h00013, f_v));
        @(posedge clk);
        err_lo <= pte_addr(22'h00013, 10'h000);
        err_hi <= pte_addr(22'h00013, 10'h3ff);
        expect_result(make_req({10'h007, 10'h0ab, 12'h456}, acc_read, prv_s, 1'b0), sv32,
                      flt_bus, '0, 2, 0);
        @(posedge clk);
        err_lo <= '1;
        err_hi <= '0;
    endtask

    task automatic flush_and_rewalk();
        mmu_req_t r;
        r = make_req({page_vpn, random_offset()}, acc_read, prv_s, 1'b0);
        expect_result(r, sv32, flt_none, {page_ppn, r.va[11:0]}, 0, 3);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        expect_result(r, sv32, flt_none, {page_ppn, r.va[11:0]}, 2, 0);
        expect_result(r, sv32, flt_none, {page_ppn, r.va[11:0]}, 0, 3);
    endtask

    initial begin
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        satp      = '0;
        flush     = 1'b0;
        err_lo    = '1;
        err_hi    = '0;
        lfsr_q    = 32'h9085fde6;
        checks    = 0;
        errors    = 0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        run_bypass();
        walk_then_hit();
        megapage_cases();
        permission_cases();
        bus_error_case();
        flush_and_rewalk();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/tb_pt_mem.sv
`timescale 1ns/1ps

module tb_pt_mem (
    input  logic              clk,
    input  logic              rstn,
    input  mmu_pkg::wb_req_t  wb,
    input  mmu_pkg::paddr_t   err_lo,
    input  mmu_pkg::paddr_t   err_hi,
    output mmu_pkg::wb_data_t dat,
    output logic              ack,
    output logic              err,
    output logic [31:0]       xfers
);
    import mmu_pkg::*;

    // sparse word store keyed by byte address
    wb_data_t mem [paddr_t];
    logic     wait_q;

    task automatic store(input paddr_t adr, input wb_data_t data);
        mem[adr] = data;
    endtask

    function automatic wb_data_t load(input paddr_t adr);
        if (mem.exists(adr)) begin
            return mem[adr];
        end
        // unwritten entries read as invalid ptes
        return '0;
    endfunction

    // one wait cycle, then ack or err for a single beat
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack    <= 1'b0;
            err    <= 1'b0;
            wait_q <= 1'b0;
            xfers  <= '0;
            dat    <= '0;
        end else begin
            ack <= 1'b0;
            err <= 1'b0;
            if (wb.cyc && wb.stb && !wb.we && !ack && !err) begin
                if (!wait_q) begin
                    wait_q <= 1'b1;
                end else begin
                    wait_q <= 1'b0;
                    xfers  <= xfers + 1;
                    if (wb.adr >= err_lo && wb.adr <= err_hi) begin
                        err <= 1'b1;
                    end else begin
                        ack <= 1'b1;
                        dat <= load(wb.adr);
                    end
                end
            end
        end
    end

endmodule

// File: vlog.f
rtl/mmu_pkg.sv
rtl/pte_perm_check.sv
rtl/tlb.sv
rtl/page_walker.sv
rtl/mmu_top.sv
testbench/tb_pt_mem.sv
testbench/tb_mmu.sv
